//--- src/vid_consts.svh
`ifndef VID_CONSTS_SVH
`define VID_CONSTS_SVH

// game colour channel width
`define VID_COLORW 4

// channel width after the bandwidth filter
`define VID_CLROUTW (`VID_COLORW + 1)

// scanline strength codes
`define VID_SL_OFF 2'd0
`define VID_SL_25  2'd1
`define VID_SL_50  2'd2
`define VID_SL_75  2'd3

// sync pin modes, code 3 falls back to separate syncs
`define VID_SYNC_SEP   2'd0
`define VID_SYNC_CSYNC 2'd1
`define VID_SYNC_SOG   2'd2

`endif

//--- src/vid_pkg.sv
`include "vid_consts.svh"

package vid_pkg;

    // one pixel on the widened 5-bit scale
    typedef struct packed {
        logic [`VID_CLROUTW-1:0] r;
        logic [`VID_CLROUTW-1:0] g;
        logic [`VID_CLROUTW-1:0] b;
    } vid_pixel_t;

    // sync and blanking travelling with each pixel
    // lhbl and lvbl are high in active video
    typedef struct packed {
        logic hs;
        logic vs;
        logic lhbl;
        logic lvbl;
    } vid_sync_t;

    // static settings, held during a frame
    typedef struct packed {
        // two-tap horizontal low-pass on/off
        logic       bw_en;
        // one of the VID_SL_* codes
        logic [1:0] scanlines;
        // one of the VID_SYNC_* codes
        logic [1:0] sync_mode;
    } vid_cfg_t;

endpackage

//--- src/vid_bw_filter.sv
`timescale 1ns/100ps
`include "vid_consts.svh"

module vid_bw_filter (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     pxl_cen_i,
    input  logic [3*`VID_COLORW-1:0] game_rgb_i,
    input  vid_pkg::vid_sync_t       game_sync_i,
    input  logic                     bw_en_i,
    output vid_pkg::vid_pixel_t      pixel_o,
    output vid_pkg::vid_sync_t       sync_o,
    output logic                     cen_o
);
    import vid_pkg::*;

    // current game pixel split into channels
    logic [`VID_COLORW-1:0] cur_r;
    logic [`VID_COLORW-1:0] cur_g;
    logic [`VID_COLORW-1:0] cur_b;

    // pixel from the previous strobe
    logic [`VID_COLORW-1:0] prev_r;
    logic [`VID_COLORW-1:0] prev_g;
    logic [`VID_COLORW-1:0] prev_b;

    vid_pixel_t filt_pixel;

    // both paths end on the same 5-bit scale
    function automatic logic [`VID_CLROUTW-1:0] filt_chan(
        input logic [`VID_COLORW-1:0] cur,
        input logic [`VID_COLORW-1:0] prev,
        input logic                   en
    );
        if (en) begin
            filt_chan = {1'b0, cur} + {1'b0, prev};
        end else begin
            filt_chan = {cur, 1'b0};
        end
    endfunction

    // red sits in the top nibble
    assign cur_r = game_rgb_i[3*`VID_COLORW-1 -: `VID_COLORW];
    assign cur_g = game_rgb_i[2*`VID_COLORW-1 -: `VID_COLORW];
    assign cur_b = game_rgb_i[`VID_COLORW-1:0];

    always_comb begin
        filt_pixel.r = filt_chan(cur_r, prev_r, bw_en_i);
        filt_pixel.g = filt_chan(cur_g, prev_g, bw_en_i);
        filt_pixel.b = filt_chan(cur_b, prev_b, bw_en_i);
    end

    // history and strobe
    always_ff @(posedge clk) begin
        if (rst_i) begin
            prev_r <= '0;
            prev_g <= '0;
            prev_b <= '0;
            cen_o  <= 1'b0;
        end else begin
            cen_o <= pxl_cen_i;
            // history follows every strobe, filter on or off
            if (pxl_cen_i) begin
                prev_r <= cur_r;
                prev_g <= cur_g;
                prev_b <= cur_b;
            end
        end
    end

    // pixel and syncs stay aligned
    always_ff @(posedge clk) begin
        if (pxl_cen_i) begin
            pixel_o <= filt_pixel;
            sync_o  <= game_sync_i;
        end
    end

endmodule

//--- src/vid_scanline.sv
`timescale 1ns/100ps
`include "vid_consts.svh"

module vid_scanline (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                cen_i,
    input  vid_pkg::vid_pixel_t pixel_i,
    input  vid_pkg::vid_sync_t  sync_i,
    input  logic [1:0]          scanlines_i,
    output vid_pkg::vid_pixel_t pixel_o,
    output vid_pkg::vid_sync_t  sync_o,
    output logic                cen_o
);
    import vid_pkg::*;

    logic       line_odd_q;
    logic       line_odd_d;
    // hs seen at the previous strobe
    logic       hs_last_q;
    logic       hs_rise;
    vid_pixel_t dim_pixel;

    function automatic logic [`VID_CLROUTW-1:0] dim_chan(
        input logic [`VID_CLROUTW-1:0] c,
        input logic [1:0]              mode
    );
        logic [`VID_CLROUTW-1:0] quarter;
        logic [`VID_CLROUTW-1:0] half;
        quarter = c >> 2;
        half    = c >> 1;
        case (mode)
            `VID_SL_25: dim_chan = c - quarter;
            `VID_SL_50: dim_chan = c - half;
            // c minus three quarters, i.e. c/4 rounded down
            `VID_SL_75: dim_chan = quarter;
            default:    dim_chan = c;
        endcase
    endfunction

    always_comb begin
        hs_rise = sync_i.hs & ~hs_last_q;
        // parity of the line this pixel belongs to
        if (sync_i.vs) begin
            line_odd_d = 1'b0;
        end else if (hs_rise) begin
            line_odd_d = ~line_odd_q;
        end else begin
            line_odd_d = line_odd_q;
        end

        dim_pixel = pixel_i;
        if (line_odd_d) begin
            dim_pixel.r = dim_chan(pixel_i.r, scanlines_i);
            dim_pixel.g = dim_chan(pixel_i.g, scanlines_i);
            dim_pixel.b = dim_chan(pixel_i.b, scanlines_i);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            line_odd_q <= 1'b0;
            hs_last_q  <= 1'b0;
            cen_o      <= 1'b0;
        end else begin
            cen_o <= cen_i;
            if (cen_i) begin
                line_odd_q <= line_odd_d;
                hs_last_q  <= sync_i.hs;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen_i) begin
            pixel_o <= dim_pixel;
            sync_o  <= sync_i;
        end
    end

endmodule

//--- src/vid_sync_out.sv
`timescale 1ns/100ps
`include "vid_consts.svh"

module vid_sync_out (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                cen_i,
    input  vid_pkg::vid_pixel_t pixel_i,
    input  vid_pkg::vid_sync_t  sync_i,
    input  logic [1:0]          sync_mode_i,
    output logic [7:0]          vga_r_o,
    output logic [7:0]          vga_g_o,
    output logic [7:0]          vga_b_o,
    output logic                video_hs_o,
    output logic                video_vs_o,
    output logic                video_de_o
);

    logic       de;
    logic       csync;
    logic [7:0] r8;
    logic [7:0] g8;
    logic [7:0] b8;
    // pin pair chosen by the sync mode
    logic       hs_pin;
    logic       vs_pin;

    // replicate the top bits into the empty low bits
    function automatic logic [7:0] stretch8(
        input logic [`VID_CLROUTW-1:0] c
    );
        stretch8 = {c, c[`VID_CLROUTW-1 -: (8 - `VID_CLROUTW)]};
    endfunction

    always_comb begin
        de    = sync_i.lhbl & sync_i.lvbl;
        csync = sync_i.hs | sync_i.vs;

        // black outside active video
        if (de) begin
            r8 = stretch8(pixel_i.r);
            g8 = stretch8(pixel_i.g);
            b8 = stretch8(pixel_i.b);
        end else begin
            r8 = 8'd0;
            g8 = 8'd0;
            b8 = 8'd0;
        end
    end

    always_comb begin
        case (sync_mode_i)
            // scart style, vs held high to select rgb
            `VID_SYNC_CSYNC: begin
                hs_pin = csync;
                vs_pin = 1'b1;
            end
            `VID_SYNC_SOG: begin
                hs_pin = 1'b1;
                vs_pin = csync;
            end
            // SEP and the spare code
            default: begin
                hs_pin = sync_i.hs;
                vs_pin = sync_i.vs;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            vga_r_o    <= 8'd0;
            vga_g_o    <= 8'd0;
            vga_b_o    <= 8'd0;
            video_hs_o <= 1'b0;
            video_vs_o <= 1'b0;
            video_de_o <= 1'b0;
        end else if (cen_i) begin
            vga_r_o    <= r8;
            vga_g_o    <= g8;
            vga_b_o    <= b8;
            video_hs_o <= hs_pin;
            video_vs_o <= vs_pin;
            video_de_o <= de;
        end
    end

endmodule

//--- src/vid_out_top.sv
`timescale 1ns/100ps
`include "vid_consts.svh"

module vid_out_top (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     pxl_cen_i,
    input  logic [3*`VID_COLORW-1:0] game_rgb_i,
    input  vid_pkg::vid_sync_t       game_sync_i,
    input  vid_pkg::vid_cfg_t        cfg_i,
    output logic [7:0]               vga_r_o,
    output logic [7:0]               vga_g_o,
    output logic [7:0]               vga_b_o,
    output logic                     video_hs_o,
    output logic                     video_vs_o,
    output logic                     video_de_o
);
    import vid_pkg::*;

    // filter to scanline stage
    vid_pixel_t pixel_a;
    vid_sync_t  sync_a;
    logic       cen_a;

    // scanline to output stage
    vid_pixel_t pixel_b;
    vid_sync_t  sync_b;
    logic       cen_b;

    vid_bw_filter vid_bw_filter_inst (
        .clk         (clk),
        .rst_i       (rst_i),
        .pxl_cen_i   (pxl_cen_i),
        .game_rgb_i  (game_rgb_i),
        .game_sync_i (game_sync_i),
        .bw_en_i     (cfg_i.bw_en),
        .pixel_o     (pixel_a),
        .sync_o      (sync_a),
        .cen_o       (cen_a)
    );

    vid_scanline vid_scanline_inst (
        .clk         (clk),
        .rst_i       (rst_i),
        .cen_i       (cen_a),
        .pixel_i     (pixel_a),
        .sync_i      (sync_a),
        .scanlines_i (cfg_i.scanlines),
        .pixel_o     (pixel_b),
        .sync_o      (sync_b),
        .cen_o       (cen_b)
    );

    vid_sync_out vid_sync_out_inst (
        .clk         (clk),
        .rst_i       (rst_i),
        .cen_i       (cen_b),
        .pixel_i     (pixel_b),
        .sync_i      (sync_b),
        .sync_mode_i (cfg_i.sync_mode),
        .vga_r_o     (vga_r_o),
        .vga_g_o     (vga_g_o),
        .vga_b_o     (vga_b_o),
        .video_hs_o  (video_hs_o),
        .video_vs_o  (video_vs_o),
        .video_de_o  (video_de_o)
    );

endmodule

//--- bench/vid_out_assert.sv
`timescale 1ns/100ps

module vid_out_assert (
    input logic               clk,
    input logic               rst_i,
    input logic               pxl_cen_i,
    input logic               cen_a,
    input logic               cen_b,
    input vid_pkg::vid_sync_t sync_b,
    input logic [7:0]         vga_r_o,
    input logic [7:0]         vga_g_o,
    input logic [7:0]         vga_b_o,
    input logic               video_de_o
);

    // assertion failures so far
    int unsigned fail_count = 0;

    // strobe moves one stage per clk
    cen_a_follows: assert property (@(posedge clk) disable iff (rst_i)
        cen_a == $past(pxl_cen_i))
        else begin
            fail_count++;
            $error("cen_a does not follow pxl_cen_i by one cycle");
        end

    cen_b_follows: assert property (@(posedge clk) disable iff (rst_i)
        cen_b == $past(cen_a))
        else begin
            fail_count++;
            $error("cen_b does not follow cen_a by one cycle");
        end

    // a blanked pixel loaded into the output stage leaves black and de low
    blank_is_dark: assert property (@(posedge clk) disable iff (rst_i)
        cen_b && !(sync_b.lhbl && sync_b.lvbl) |=>
            !video_de_o && vga_r_o == 8'd0 && vga_g_o == 8'd0 && vga_b_o == 8'd0)
        else begin
            fail_count++;
            $error("video_de_o or colour active for a blanked pixel");
        end

endmodule

bind vid_out_top vid_out_assert vid_out_assert_inst (
    .clk        (clk),
    .rst_i      (rst_i),
    .pxl_cen_i  (pxl_cen_i),
    .cen_a      (cen_a),
    .cen_b      (cen_b),
    .sync_b     (sync_b),
    .vga_r_o    (vga_r_o),
    .vga_g_o    (vga_g_o),
    .vga_b_o    (vga_b_o),
    .video_de_o (video_de_o)
);

//--- bench/vid_out_tb.sv
`timescale 1ns/100ps
`include "vid_consts.svh"

module vid_out_tb;
    import vid_pkg::*;

    localparam int N_PASS = 16;
    localparam int N_FILT = 16;
    localparam int SL_LINES = 6;
    // active pixels after each hs pixel
    localparam int SL_ACTIVE = 3;
    localparam int SL_PIXELS = 1 + SL_LINES * (1 + SL_ACTIVE);
    localparam int N_BLANK = 8;
    localparam int N_SYNC = 16;
    localparam int N_PIXELS = N_PASS + N_FILT + 3 * SL_PIXELS + N_BLANK + N_SYNC;
    // 4 clks per pixel plus two resets and some slack
    localparam int unsigned TEST_CYCLES = 4 * N_PIXELS + 16;
    localparam int unsigned TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic        clk;
    logic        rst_i;
    logic        pxl_cen_i;
    logic [11:0] game_rgb_i;
    vid_sync_t   game_sync_i;
    vid_cfg_t    cfg_i;
    logic [7:0]  vga_r_o;
    logic [7:0]  vga_g_o;
    logic [7:0]  vga_b_o;
    logic        video_hs_o;
    logic        video_vs_o;
    logic        video_de_o;

    // reference model state
    logic [3:0]  hist_r = 4'd0;
    logic [3:0]  hist_g = 4'd0;
    logic [3:0]  hist_b = 4'd0;
    logic        ref_odd = 1'b0;
    logic        ref_hs_last = 1'b0;

    int unsigned cycle_count = 0;

    vid_out_top vid_out_top_inst (
        .clk         (clk),
        .rst_i       (rst_i),
        .pxl_cen_i   (pxl_cen_i),
        .game_rgb_i  (game_rgb_i),
        .game_sync_i (game_sync_i),
        .cfg_i       (cfg_i),
        .vga_r_o     (vga_r_o),
        .vga_g_o     (vga_g_o),
        .vga_b_o     (vga_b_o),
        .video_hs_o  (video_hs_o),
        .video_vs_o  (video_vs_o),
        .video_de_o  (video_de_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("TB FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (actual !== expected) begin
            $display("Error: time %0t, %s expected 0x%02h, actual 0x%02h",
                     $time, name, expected, actual);
            stop_with_failure("output value mismatch");
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 32'd1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_failure("timeout: the tests ran longer than their cycle budget");
        end
    end

    function automatic vid_sync_t make_sync(input logic hs, input logic vs,
                                            input logic lhbl, input logic lvbl);
        vid_sync_t s;
        s.hs   = hs;
        s.vs   = vs;
        s.lhbl = lhbl;
        s.lvbl = lvbl;
        return s;
    endfunction

    function automatic vid_cfg_t make_cfg(input logic bw, input logic [1:0] sl,
                                          input logic [1:0] sm);
        vid_cfg_t c;
        c.bw_en     = bw;
        c.scanlines = sl;
        c.sync_mode = sm;
        return c;
    endfunction

    function automatic logic [11:0] random_rgb();
        logic [31:0] rnd;
        rnd = $urandom;
        return rnd[11:0];
    endfunction

    // sum of two taps or the lone pixel doubled
    function automatic logic [4:0] filter_ref(input logic [3:0] cur, input logic [3:0] prev,
                                              input logic en);
        if (en) begin
            return 5'(cur) + 5'(prev);
        end
        return 5'(cur) * 5'd2;
    endfunction

    function automatic logic [4:0] dim_ref(input logic [4:0] c, input logic [1:0] mode);
        case (mode)
            `VID_SL_25: return c - c / 5'd4;
            `VID_SL_50: return c - c / 5'd2;
            `VID_SL_75: return c / 5'd4;
            default:    return c;
        endcase
    endfunction

    function automatic logic [7:0] stretch_ref(input logic [4:0] c);
        return (8'(c) << 3) | (8'(c) >> 2);
    endfunction

    task automatic clear_model();
        hist_r = 4'd0;
        hist_g = 4'd0;
        hist_b = 4'd0;
        ref_odd = 1'b0;
        ref_hs_last = 1'b0;
    endtask

    // drive one strobe and compare once the pixel has passed all stages
    task automatic send_pixel(input logic [11:0] rgb, input vid_sync_t sync,
                              input vid_cfg_t cfg);
        logic [4:0] fr;
        logic [4:0] fg;
        logic [4:0] fb;
        logic       de;
        logic       csync;
        logic       exp_hs;
        logic       exp_vs;
        fr = filter_ref(rgb[11:8], hist_r, cfg.bw_en);
        fg = filter_ref(rgb[7:4], hist_g, cfg.bw_en);
        fb = filter_ref(rgb[3:0], hist_b, cfg.bw_en);
        hist_r = rgb[11:8];
        hist_g = rgb[7:4];
        hist_b = rgb[3:0];
        if (sync.vs) begin
            ref_odd = 1'b0;
        end else if (sync.hs && !ref_hs_last) begin
            ref_odd = !ref_odd;
        end
        ref_hs_last = sync.hs;
        if (ref_odd) begin
            fr = dim_ref(fr, cfg.scanlines);
            fg = dim_ref(fg, cfg.scanlines);
            fb = dim_ref(fb, cfg.scanlines);
        end
        de = sync.lhbl && sync.lvbl;
        csync = sync.hs || sync.vs;
        case (cfg.sync_mode)
            `VID_SYNC_CSYNC: {exp_hs, exp_vs} = {csync, 1'b1};
            `VID_SYNC_SOG:   {exp_hs, exp_vs} = {1'b1, csync};
            default:         {exp_hs, exp_vs} = {sync.hs, sync.vs};
        endcase

        @(posedge clk);
        pxl_cen_i   <= 1'b1;
        game_rgb_i  <= rgb;
        game_sync_i <= sync;
        cfg_i       <= cfg;
        @(posedge clk);
        pxl_cen_i <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("vga_r_o", de ? stretch_ref(fr) : 8'd0, vga_r_o);
        check_value("vga_g_o", de ? stretch_ref(fg) : 8'd0, vga_g_o);
        check_value("vga_b_o", de ? stretch_ref(fb) : 8'd0, vga_b_o);
        check_value("video_hs_o", {7'd0, exp_hs}, {7'd0, video_hs_o});
        check_value("video_vs_o", {7'd0, exp_vs}, {7'd0, video_vs_o});
        check_value("video_de_o", {7'd0, de}, {7'd0, video_de_o});
    endtask

    task automatic expect_idle_outputs();
        check_value("vga_r_o", 8'd0, vga_r_o);
        check_value("vga_g_o", 8'd0, vga_g_o);
        check_value("vga_b_o", 8'd0, vga_b_o);
        check_value("video_hs_o", 8'd0, {7'd0, video_hs_o});
        check_value("video_vs_o", 8'd0, {7'd0, video_vs_o});
        check_value("video_de_o", 8'd0, {7'd0, video_de_o});
    endtask

    // reset is already high from time 0
    task automatic reset_clears_outputs();
        @(posedge clk);
        @(negedge clk);
        expect_idle_outputs();
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        expect_idle_outputs();
    endtask

    task automatic passthrough_pixels();
        for (int i = 0; i < N_PASS; i++) begin
            send_pixel(random_rgb(), make_sync(0, 0, 1, 1),
                       make_cfg(0, `VID_SL_OFF, `VID_SYNC_SEP));
        end
    endtask

    // fresh reset so the first pixel sums with an empty history
    task automatic filter_pixel_pairs();
        @(posedge clk);
        rst_i <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        // outputs were live before this reset
        expect_idle_outputs();
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;
        clear_model();
        for (int i = 0; i < N_FILT; i++) begin
            send_pixel(random_rgb(), make_sync(0, 0, 1, 1),
                       make_cfg(1, `VID_SL_OFF, `VID_SYNC_SEP));
        end
    endtask

    task automatic scanline_frames();
        vid_cfg_t cfg;
        for (int m = 1; m < 4; m++) begin
            cfg = make_cfg(1, 2'(m), `VID_SYNC_SEP);
            send_pixel(random_rgb(), make_sync(0, 1, 0, 0), cfg);
            for (int ln = 0; ln < SL_LINES; ln++) begin
                send_pixel(random_rgb(), make_sync(1, 0, 0, 1), cfg);
                for (int p = 0; p < SL_ACTIVE; p++) begin
                    send_pixel(random_rgb(), make_sync(0, 0, 1, 1), cfg);
                end
            end
        end
    endtask

    task automatic blanked_pixels();
        for (int i = 0; i < N_BLANK; i++) begin
            send_pixel(random_rgb(), make_sync(0, 0, i[0], i[1]),
                       make_cfg(0, `VID_SL_OFF, `VID_SYNC_SEP));
        end
    endtask

    // every hs/vs pair in every sync code including the spare one
    task automatic sync_mode_patterns();
        for (int m = 0; m < 4; m++) begin
            for (int p = 0; p < 4; p++) begin
                send_pixel(random_rgb(), make_sync(p[0], p[1], 1, 1),
                           make_cfg(0, `VID_SL_OFF, 2'(m)));
            end
        end
    endtask

    initial begin
        void'($urandom(32'h190a_74fc));
        rst_i       = 1'b1;
        pxl_cen_i   = 1'b0;
        game_rgb_i  = 12'd0;
        game_sync_i = '0;
        cfg_i       = '0;

        reset_clears_outputs();
        passthrough_pixels();
        filter_pixel_pairs();
        scanline_frames();
        blanked_pixels();
        sync_mode_patterns();

        if (vid_out_top_inst.vid_out_assert_inst.fail_count != 0) begin
            stop_with_failure("a bound assertion on the DUT failed");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

//--- files.f
+incdir+src
src/vid_pkg.sv
src/vid_bw_filter.sv
src/vid_scanline.sv
src/vid_sync_out.sv
src/vid_out_top.sv
bench/vid_out_assert.sv
bench/vid_out_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator and run it; exit status carries the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module vid_out_tb -f files.f -o vid_out_sim &&
./obj_dir/vid_out_sim || exit 1
